// ==== include/video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// frame geometry, in pixels and lines
`define VID_H_TOTAL     448
`define VID_V_TOTAL     320

`define VID_HSYNC_BEG   8
`define VID_HSYNC_LEN   32
`define VID_VSYNC_BEG   0
`define VID_VSYNC_LEN   2

// active window, 256 x 192
`define VID_HPIX_BEG    64
`define VID_HPIX_END    320
`define VID_VPIX_BEG    40
`define VID_VPIX_END    232

`define VID_HBLANK_END  40
`define VID_VBLANK_END  8

// port and bus widths
`define VID_CNT_W       9
`define VID_BYTE_W      8
`define VID_ADDR_W      21
`define VID_DATA_W      16
`define VID_RGB_W       15
`define VID_CRAM_DEPTH  256

`endif

// ==== logic/video_fetch.sv ====
`timescale 1ns/100ps

module video_fetch import video_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,

  vid_cfg_if.fetch  cfg,
  vid_beam_if.fetch beam,

  input  logic   video_strobe,
  input  vdata_t dram_rdata,

  output vaddr_t video_addr,
  output vdata_t fetch_data
);

  cnt_t yline;
  cnt_t xpos;

  // line part of the address, fixed for the whole line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      yline <= '0;
    end else if (beam.line_start) begin
      yline <= beam.cnt_row + cfg.gy_offs;
    end
  end

  // next group, the beam is four pixels behind it at video_go
  assign xpos = beam.cnt_col + cnt_t'(4) + cfg.gx_offs;

  // 64 words per line, wraps inside the page
  assign video_addr = {cfg.vpage, yline[6:0], xpos[7:2]};

  always_ff @(posedge clk) begin
    if (video_strobe) begin
      fetch_data <= dram_rdata;
    end
  end

endmodule

// ==== logic/video_if.sv ====
`timescale 1ns/100ps

// configuration registers as seen by the video blocks
interface vid_cfg_if import video_pkg::*; ();

  byte_t border;
  byte_t vpage;
  byte_t vconf;
  byte_t palsel;
  cnt_t  gx_offs;
  cnt_t  gy_offs;
  byte_t hint_beg;
  cnt_t  vint_beg;

  modport ports  (output border, vpage, vconf, palsel, gx_offs, gy_offs, hint_beg, vint_beg);
  modport sync   (input vint_beg, hint_beg, vconf);
  modport fetch  (input vpage, gx_offs, gy_offs);
  modport render (input border, palsel);

endinterface

// beam timing from the sync generator
interface vid_beam_if import video_pkg::*; ();

  logic pix_stb;
  logic line_start;
  logic hvpix;
  logic blank;
  logic grp_start;
  cnt_t cnt_col;
  cnt_t cnt_row;
  // raw DAC select, follows vconf bit 2
  logic dac_mode;

  modport src    (output pix_stb, line_start, hvpix, blank, grp_start, cnt_col, cnt_row,
                  dac_mode);
  modport fetch  (input line_start, cnt_col, cnt_row);
  modport render (input pix_stb, grp_start, hvpix);
  modport out    (input pix_stb, blank, dac_mode);

endinterface

// ==== logic/video_out.sv ====
`timescale 1ns/100ps
`include "video_defs.svh"

module video_out import video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  vid_beam_if.out    beam,

  input  plex_t      vplex,

  // colour RAM write port
  input  byte_t      zma,
  input  vdata_t     zmd,
  input  logic       cram_we,

  output logic [4:0] vred_raw,
  output logic [4:0] vgrn_raw,
  output logic [4:0] vblu_raw,
  output logic [1:0] vred,
  output logic [1:0] vgrn,
  output logic [1:0] vblu,
  output logic       vdac_mode
);

  rgb15_t cram [`VID_CRAM_DEPTH];
  rgb15_t pix_q;
  logic   blank_d1;
  logic   blank_d2;

  always_ff @(posedge clk) begin
    if (cram_we) begin
      cram[zma] <= zmd[14:0];
    end
  end

  // blank delayed to match the render pipeline
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      blank_d1 <= 1'b1;
      blank_d2 <= 1'b1;
    end else if (beam.pix_stb) begin
      blank_d1 <= beam.blank;
      blank_d2 <= blank_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (beam.pix_stb) begin
      pix_q <= blank_d2 ? '0 : cram[vplex];
    end
  end

  assign vred_raw = pix_q[14:10];
  assign vgrn_raw = pix_q[9:5];
  assign vblu_raw = pix_q[4:0];

  // 2-bit DAC gets the msbs
  assign vred = vred_raw[4:3];
  assign vgrn = vgrn_raw[4:3];
  assign vblu = vblu_raw[4:3];

  assign vdac_mode = beam.dac_mode;

endmodule

// ==== logic/video_pkg.sv ====
`include "video_defs.svh"

package video_pkg;

  // pixel or line count
  typedef logic [`VID_CNT_W-1:0] cnt_t;

  // plain register value from the bus
  typedef logic [`VID_BYTE_W-1:0] byte_t;

  // colour index into colour RAM
  typedef logic [`VID_BYTE_W-1:0] plex_t;

  // 5:5:5, red on top
  typedef logic [`VID_RGB_W-1:0] rgb15_t;

  // DRAM word address and data
  typedef logic [`VID_ADDR_W-1:0] vaddr_t;
  typedef logic [`VID_DATA_W-1:0] vdata_t;

endpackage

// ==== logic/video_ports.sv ====
`timescale 1ns/100ps

module video_ports import video_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  byte_t d,

  input  logic  border_wr,
  input  logic  vpage_wr,
  input  logic  vconf_wr,
  input  logic  palsel_wr,
  input  logic  gx_offsl_wr,
  input  logic  gx_offsh_wr,
  input  logic  gy_offsl_wr,
  input  logic  gy_offsh_wr,
  input  logic  hint_beg_wr,
  input  logic  vint_begl_wr,
  input  logic  vint_begh_wr,

  input  logic  line_start_s,

  vid_cfg_if.ports cfg
);

  // page written by the bus, applied at the next line
  byte_t vpage_shadow;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.border   <= '0;
      vpage_shadow <= '0;
      cfg.vpage    <= '0;
      cfg.vconf    <= '0;
      cfg.palsel   <= '0;
      cfg.gx_offs  <= '0;
      cfg.gy_offs  <= '0;
      cfg.hint_beg <= '0;
      cfg.vint_beg <= '0;
    end else begin
      if (border_wr)    cfg.border   <= d;
      if (vpage_wr)     vpage_shadow <= d;
      if (line_start_s) cfg.vpage    <= vpage_shadow;
      if (vconf_wr)     cfg.vconf    <= d;
      if (palsel_wr)    cfg.palsel   <= d;
      if (hint_beg_wr)  cfg.hint_beg <= d;

      // 9-bit values, high strobe carries bit 8 in d[0]
      if (gx_offsl_wr)  cfg.gx_offs[7:0] <= d;
      if (gx_offsh_wr)  cfg.gx_offs[8]   <= d[0];
      if (gy_offsl_wr)  cfg.gy_offs[7:0] <= d;
      if (gy_offsh_wr)  cfg.gy_offs[8]   <= d[0];
      if (vint_begl_wr) cfg.vint_beg[7:0] <= d;
      if (vint_begh_wr) cfg.vint_beg[8]   <= d[0];
    end
  end

endmodule

// ==== logic/video_render.sv ====
`timescale 1ns/100ps

module video_render import video_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,

  vid_cfg_if.render  cfg,
  vid_beam_if.render beam,

  input  vdata_t fetch_data,
  output plex_t  vplex
);

  vdata_t     shifter;
  logic [3:0] nibble;
  logic       hvpix_d;

  // last word latched is reused when no new one came in
  always_ff @(posedge clk) begin
    if (beam.grp_start) begin
      shifter <= fetch_data;
    end else if (beam.pix_stb) begin
      shifter <= {shifter[11:0], 4'h0};
    end
  end

  // leftmost pixel sits in the top nibble
  assign nibble = shifter[15:12];

  // window flag lined up with the shifter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hvpix_d <= 1'b0;
    end else if (beam.pix_stb) begin
      hvpix_d <= beam.hvpix;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vplex <= '0;
    end else if (beam.pix_stb) begin
      vplex <= hvpix_d ? {cfg.palsel[3:0], nibble} : cfg.border;
    end
  end

endmodule

// ==== logic/video_sync.sv ====
`timescale 1ns/100ps
`include "video_defs.svh"

module video_sync import video_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic c3,

  vid_cfg_if.sync  cfg,
  vid_beam_if.src  beam,

  output logic hsync,
  output logic vsync,
  output logic csync,
  output logic int_start,
  output logic line_start_s,
  output logic video_go
);

  cnt_t hcnt;
  cnt_t vcnt;
  logic h_last;
  logic v_last;

  // raw decodes of the counters
  logic hs_on;
  logic vs_on;
  logic hpix;
  logic vpix;
  logic hfetch;
  logic blank_c;
  cnt_t col;
  cnt_t row;

  // registered beam state
  logic hvpix_r;
  logic blank_r;
  logic grp_start_r;
  logic dac_mode_r;
  cnt_t cnt_col_r;
  cnt_t cnt_row_r;

  assign h_last = (hcnt == cnt_t'(`VID_H_TOTAL - 1));
  assign v_last = (vcnt == cnt_t'(`VID_V_TOTAL - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (c3) begin
      if (h_last) begin
        hcnt <= '0;
        vcnt <= v_last ? '0 : vcnt + 1'b1;
      end else begin
        hcnt <= hcnt + 1'b1;
      end
    end
  end

  assign hs_on   = (hcnt >= `VID_HSYNC_BEG) && (hcnt < `VID_HSYNC_BEG + `VID_HSYNC_LEN);
  assign vs_on   = (vcnt >= `VID_VSYNC_BEG) && (vcnt < `VID_VSYNC_BEG + `VID_VSYNC_LEN);
  assign hpix    = (hcnt >= `VID_HPIX_BEG) && (hcnt < `VID_HPIX_END);
  assign vpix    = (vcnt >= `VID_VPIX_BEG) && (vcnt < `VID_VPIX_END);
  // fetch window runs one group ahead of the beam
  assign hfetch  = (hcnt >= `VID_HPIX_BEG - 4) && (hcnt < `VID_HPIX_END - 4);
  assign blank_c = (hcnt < `VID_HBLANK_END) || (vcnt < `VID_VBLANK_END);

  // in-window position, wraps below the window start
  assign col = hcnt - cnt_t'(`VID_HPIX_BEG);
  assign row = vcnt - cnt_t'(`VID_VPIX_BEG);

  // levels, advance with the pixel strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync      <= 1'b1;
      vsync      <= 1'b1;
      csync      <= 1'b1;
      blank_r    <= 1'b1;
      hvpix_r    <= 1'b0;
      dac_mode_r <= 1'b0;
      cnt_col_r  <= '0;
      cnt_row_r  <= '0;
    end else if (c3) begin
      hsync      <= !hs_on;
      vsync      <= !vs_on;
      csync      <= !(hs_on || vs_on);
      blank_r    <= blank_c;
      hvpix_r    <= hpix && vpix;
      dac_mode_r <= cfg.vconf[2];
      cnt_col_r  <= col;
      cnt_row_r  <= row;
    end
  end

  // one-clock pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_start_s <= 1'b0;
      grp_start_r  <= 1'b0;
      video_go     <= 1'b0;
      int_start    <= 1'b0;
    end else begin
      line_start_s <= c3 && (hcnt == '0);
      grp_start_r  <= c3 && hpix && vpix && (col[1:0] == 2'd0);
      video_go     <= c3 && hfetch && vpix && (col[1:0] == 2'd0);
      int_start    <= c3 && (vcnt == cfg.vint_beg) && (hcnt == {1'b0, cfg.hint_beg});
    end
  end

  assign beam.pix_stb    = c3;
  assign beam.line_start = line_start_s;
  assign beam.hvpix      = hvpix_r;
  assign beam.blank      = blank_r;
  assign beam.grp_start  = grp_start_r;
  assign beam.cnt_col    = cnt_col_r;
  assign beam.cnt_row    = cnt_row_r;
  assign beam.dac_mode   = dac_mode_r;

endmodule

// ==== logic/video_top.sv ====
`timescale 1ns/100ps

module video_top import video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       c3,

  // bus side
  input  byte_t      d,
  input  vdata_t     zmd,
  input  byte_t      zma,
  input  logic       cram_we,

  input  logic       border_wr,
  input  logic       vpage_wr,
  input  logic       vconf_wr,
  input  logic       palsel_wr,
  input  logic       gx_offsl_wr,
  input  logic       gx_offsh_wr,
  input  logic       gy_offsl_wr,
  input  logic       gy_offsh_wr,
  input  logic       hint_beg_wr,
  input  logic       vint_begl_wr,
  input  logic       vint_begh_wr,

  // syncs and interrupt
  output logic       hsync,
  output logic       vsync,
  output logic       csync,
  output logic       int_start,
  output logic       line_start_s,

  // DRAM
  output vaddr_t     video_addr,
  output logic       video_go,
  input  logic       video_strobe,
  input  vdata_t     dram_rdata,

  // colour
  output logic [4:0] vred_raw,
  output logic [4:0] vgrn_raw,
  output logic [4:0] vblu_raw,
  output logic [1:0] vred,
  output logic [1:0] vgrn,
  output logic [1:0] vblu,
  output logic       vdac_mode
);

  vdata_t fetch_data;
  plex_t  vplex;

  vid_cfg_if  cfg_if ();
  vid_beam_if beam_if ();

  video_ports video_ports (
    .clk          (clk),
    .rst_n        (rst_n),
    .d            (d),
    .border_wr    (border_wr),
    .vpage_wr     (vpage_wr),
    .vconf_wr     (vconf_wr),
    .palsel_wr    (palsel_wr),
    .gx_offsl_wr  (gx_offsl_wr),
    .gx_offsh_wr  (gx_offsh_wr),
    .gy_offsl_wr  (gy_offsl_wr),
    .gy_offsh_wr  (gy_offsh_wr),
    .hint_beg_wr  (hint_beg_wr),
    .vint_begl_wr (vint_begl_wr),
    .vint_begh_wr (vint_begh_wr),
    .line_start_s (line_start_s),
    .cfg          (cfg_if)
  );

  video_sync video_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .c3           (c3),
    .cfg          (cfg_if),
    .beam         (beam_if),
    .hsync        (hsync),
    .vsync        (vsync),
    .csync        (csync),
    .int_start    (int_start),
    .line_start_s (line_start_s),
    .video_go     (video_go)
  );

  video_fetch video_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg_if),
    .beam         (beam_if),
    .video_strobe (video_strobe),
    .dram_rdata   (dram_rdata),
    .video_addr   (video_addr),
    .fetch_data   (fetch_data)
  );

  video_render video_render (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg_if),
    .beam       (beam_if),
    .fetch_data (fetch_data),
    .vplex      (vplex)
  );

  video_out video_out (
    .clk       (clk),
    .rst_n     (rst_n),
    .beam      (beam_if),
    .vplex     (vplex),
    .zma       (zma),
    .zmd       (zmd),
    .cram_we   (cram_we),
    .vred_raw  (vred_raw),
    .vgrn_raw  (vgrn_raw),
    .vblu_raw  (vblu_raw),
    .vred      (vred),
    .vgrn      (vgrn),
    .vblu      (vblu),
    .vdac_mode (vdac_mode)
  );

endmodule

// ==== sim.f ====
+incdir+include
logic/video_pkg.sv
logic/video_if.sv
logic/video_ports.sv
logic/video_sync.sv
logic/video_fetch.sv
logic/video_render.sv
logic/video_out.sv
logic/video_top.sv
tb/video_tb.sv

// ==== tb/video_tb.sv ====
`timescale 1ns/100ps
`include "video_defs.svh"

module video_tb import video_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int FRAME_CLKS = `VID_H_TOTAL * `VID_V_TOTAL;
  // sync two frames, interrupt three, border and pixels one each, one spare
  localparam int WATCHDOG_CLKS = 8 * FRAME_CLKS;
  localparam logic [31:0] SEED = 32'd46976;

  // write strobe bits
  localparam int P_BORDER = 0;
  localparam int P_VPAGE  = 1;
  localparam int P_VCONF  = 2;
  localparam int P_PALSEL = 3;
  localparam int P_GXL    = 4;
  localparam int P_GXH    = 5;
  localparam int P_GYL    = 6;
  localparam int P_GYH    = 7;
  localparam int P_HINT   = 8;
  localparam int P_VINTL  = 9;
  localparam int P_VINTH  = 10;

  logic        clk;
  logic        rst_n;
  logic        c3;
  byte_t       d;
  vdata_t      zmd;
  byte_t       zma;
  logic        cram_we;
  logic [10:0] wr_stb;
  logic        hsync;
  logic        vsync;
  logic        csync;
  logic        int_start;
  logic        line_start_s;
  vaddr_t      video_addr;
  logic        video_go;
  logic        video_strobe;
  vdata_t      dram_rdata;
  logic [4:0]  vred_raw;
  logic [4:0]  vgrn_raw;
  logic [4:0]  vblu_raw;
  logic [1:0]  vred;
  logic [1:0]  vgrn;
  logic [1:0]  vblu;
  logic        vdac_mode;
  rgb15_t      rgb_out;
  logic [5:0]  dac_out;

  int     cyc = 0;
  int     pos;
  logic   go_s;
  vaddr_t addr_s;
  logic   go_d;
  vaddr_t addr_d;

  assign rgb_out = {vred_raw, vgrn_raw, vblu_raw};
  assign dac_out = {vred, vgrn, vblu};

  video_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .c3           (c3),
    .d            (d),
    .zmd          (zmd),
    .zma          (zma),
    .cram_we      (cram_we),
    .border_wr    (wr_stb[P_BORDER]),
    .vpage_wr     (wr_stb[P_VPAGE]),
    .vconf_wr     (wr_stb[P_VCONF]),
    .palsel_wr    (wr_stb[P_PALSEL]),
    .gx_offsl_wr  (wr_stb[P_GXL]),
    .gx_offsh_wr  (wr_stb[P_GXH]),
    .gy_offsl_wr  (wr_stb[P_GYL]),
    .gy_offsh_wr  (wr_stb[P_GYH]),
    .hint_beg_wr  (wr_stb[P_HINT]),
    .vint_begl_wr (wr_stb[P_VINTL]),
    .vint_begh_wr (wr_stb[P_VINTH]),
    .hsync        (hsync),
    .vsync        (vsync),
    .csync        (csync),
    .int_start    (int_start),
    .line_start_s (line_start_s),
    .video_addr   (video_addr),
    .video_go     (video_go),
    .video_strobe (video_strobe),
    .dram_rdata   (dram_rdata),
    .vred_raw     (vred_raw),
    .vgrn_raw     (vgrn_raw),
    .vblu_raw     (vblu_raw),
    .vred         (vred),
    .vgrn         (vgrn),
    .vblu         (vblu),
    .vdac_mode    (vdac_mode)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // DRAM content, a hash of the word address
  function automatic vdata_t dram_word(input vaddr_t a);
    logic [31:0] h;
    h = xorshift32(SEED ^ {11'b0, a});
    return h[15:0];
  endfunction

  // distinct colour for each of the 256 indices
  function automatic rgb15_t cram_colour(input byte_t a);
    return rgb15_t'(int'(a) * 123 + 77);
  endfunction

  // top two bits of red, green and blue
  function automatic logic [5:0] dac_bits(input rgb15_t c);
    return {c[14:13], c[9:8], c[4:3]};
  endfunction

  // DRAM model, answers two clocks after video_go
  always @(negedge clk) begin
    go_s   = video_go;
    addr_s = video_addr;
  end

  always @(posedge clk) begin
    go_d         <= go_s;
    addr_d       <= addr_s;
    video_strobe <= go_d;
    dram_rdata   <= dram_word(addr_d);
  end

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input rgb15_t exp, input rgb15_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input vaddr_t exp, input vaddr_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
    if (exp !== act) begin
      $display("Error: %s expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_clocks(input string name, input int exp, input int act);
    if (exp !== act) begin
      $display("Error: %s expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_dac(input string name, input logic [5:0] exp, input logic [5:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic write_port(input int port, input byte_t value);
    @(posedge clk);
    d      <= value;
    wr_stb <= 11'(1) << port;
    @(posedge clk);
    wr_stb <= '0;
  endtask

  task automatic write_cram(input byte_t addr, input rgb15_t colour);
    @(posedge clk);
    zma     <= addr;
    zmd     <= {1'b0, colour};
    cram_we <= 1'b1;
    @(posedge clk);
    cram_we <= 1'b0;
  endtask

  // stops just after the clock where the line counter starts the given line
  task automatic goto_line(input int line);
    int n;
    n = 0;
    do @(negedge clk); while (vsync !== 1'b1);
    do @(negedge clk); while (vsync !== 1'b0);
    while (n < line) begin
      @(negedge clk);
      if (line_start_s) n++;
    end
    pos = 0;
  endtask

  task automatic step_to(input int k);
    while (pos < k) begin
      @(negedge clk);
      pos++;
    end
  endtask

  task automatic wait_int(output int t);
    do @(negedge clk); while (int_start !== 1'b1);
    t = cyc;
  endtask

  task automatic check_idle(input string name);
    check_level({name, " hsync"}, 1'b1, hsync);
    check_level({name, " vsync"}, 1'b1, vsync);
    check_level({name, " csync"}, 1'b1, csync);
    check_level({name, " int_start"}, 1'b0, int_start);
    check_level({name, " video_go"}, 1'b0, video_go);
  endtask

  task automatic test_reset();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_idle("reset held");
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle("reset released");
  endtask

  task automatic test_sync();
    logic hs_q;
    logic vs_q;
    int   h_fall [$];
    int   v_fall [$];
    int   h_rise;
    int   n_hs;
    int   n_cs;
    int   n_ls;
    hs_q   = hsync;
    vs_q   = vsync;
    h_rise = -1;
    n_hs   = 0;
    n_cs   = 0;
    n_ls   = 0;
    while (v_fall.size() < 2) begin
      @(negedge clk);
      if (hs_q && !hsync) begin
        h_fall.push_back(cyc);
        if (v_fall.size() == 1) n_hs++;
      end
      if (!hs_q && hsync && h_rise < 0 && h_fall.size() > 0) h_rise = cyc;
      if (vs_q && !vsync) v_fall.push_back(cyc);
      // one whole frame between the two vsync falls
      if (v_fall.size() == 1 && !csync) n_cs++;
      if (v_fall.size() == 1 && line_start_s) n_ls++;
      hs_q = hsync;
      vs_q = vsync;
    end
    check_cnt("hsync period", cnt_t'(`VID_H_TOTAL), cnt_t'(h_fall[1] - h_fall[0]));
    check_cnt("hsync width", cnt_t'(`VID_HSYNC_LEN), cnt_t'(h_rise - h_fall[0]));
    check_cnt("lines per frame", cnt_t'(`VID_V_TOTAL), cnt_t'(n_hs));
    check_cnt("line starts per frame", cnt_t'(`VID_V_TOTAL), cnt_t'(n_ls));
    check_clocks("csync low clocks",
                 `VID_VSYNC_LEN * `VID_H_TOTAL +
                 (`VID_V_TOTAL - `VID_VSYNC_LEN) * `VID_HSYNC_LEN, n_cs);
  endtask

  task automatic test_interrupt();
    int t0;
    int t1;
    int t2;
    wait_int(t0);
    wait_int(t1);
    check_clocks("interrupt period", FRAME_CLKS, t1 - t0);
    // move past line 5 so the new position lands in the next frame
    repeat (8 * `VID_H_TOTAL) @(posedge clk);
    write_port(P_VINTL, 8'd5);
    write_port(P_VINTH, 8'd0);
    wait_int(t2);
    check_clocks("interrupt moved", FRAME_CLKS + 5 * `VID_H_TOTAL, t2 - t1);
  endtask

  task automatic test_dac_mode();
    check_level("dac mode off", 1'b0, vdac_mode);
    write_port(P_VCONF, 8'h04);
    // port latch, then the beam register
    repeat (2) @(negedge clk);
    check_level("dac mode on", 1'b1, vdac_mode);
  endtask

  task automatic test_border();
    for (int i = 0; i < `VID_CRAM_DEPTH; i++) begin
      write_cram(byte_t'(i), cram_colour(byte_t'(i)));
    end
    write_port(P_BORDER, 8'hA5);
    goto_line(20);
    step_to(10 + 3);
    check_rgb("blank", '0, rgb_out);
    step_to(100 + 3);
    check_rgb("border", cram_colour(8'hA5), rgb_out);
    check_dac("border dac", dac_bits(cram_colour(8'hA5)), dac_out);
  endtask

  task automatic test_pixels();
    cnt_t   gx;
    cnt_t   gy;
    int     y;
    int     x;
    vaddr_t exp_addr;
    vdata_t word;
    gx = 9'h108;
    gy = 9'h105;
    write_port(P_PALSEL, 8'h3C);
    write_port(P_VPAGE, 8'h12);
    write_port(P_GXL, gx[7:0]);
    write_port(P_GXH, {7'b0, gx[8]});
    write_port(P_GYL, gy[7:0]);
    write_port(P_GYH, {7'b0, gy[8]});
    // line 50 is window row 10, first group at column 0
    y = (10 + gy) % 128;
    x = ((0 + gx) / 4) % 64;
    exp_addr = {8'h12, y[6:0], x[5:0]};
    word = dram_word(exp_addr);
    goto_line(50);
    step_to(`VID_HPIX_BEG - 4);
    check_level("prefetch video_go", 1'b1, video_go);
    check_addr("prefetch address", exp_addr, video_addr);
    step_to(`VID_HPIX_BEG + 3);
    check_rgb("first pixel", cram_colour({4'hC, word[15:12]}), rgb_out);
    check_dac("first pixel dac", dac_bits(cram_colour({4'hC, word[15:12]})), dac_out);
    step_to(`VID_HPIX_BEG + 4);
    check_rgb("second pixel", cram_colour({4'hC, word[11:8]}), rgb_out);
  endtask

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("watchdog timeout, the tests did not finish in %0d clocks", WATCHDOG_CLKS);
    stop_run();
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    c3           = 1'b1;
    d            = '0;
    zmd          = '0;
    zma          = '0;
    cram_we      = 1'b0;
    wr_stb       = '0;
    video_strobe = 1'b0;
    dram_rdata   = '0;
    go_d         = 1'b0;
    addr_d       = '0;
    pos          = 0;
    test_reset();
    test_sync();
    test_interrupt();
    test_dac_mode();
    test_border();
    test_pixels();
    $display("Finished with no errors");
    $finish;
  end

endmodule
